/* include/blit_defaults.svh */
`ifndef BLIT_DEFAULTS_SVH
`define BLIT_DEFAULTS_SVH

// source block table and the two framebuffer banks
`define BLIT_SRC_BASE        22'h300000
`define BLIT_SRC_LANE_STRIDE 22'h001E00
`define BLIT_DST_BASE0       22'h100000
`define BLIT_DST_BASE1       22'h200000

// block geometry in words
`define BLIT_ROW_WORDS       16
`define BLIT_ROWS            480
`define BLIT_DST_ROW_GAP     22'h000018

`endif

/* src/mem_pkg.sv */
package mem_pkg;

  // external memory geometry, one word per address
  localparam int ADDR_W = 22;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;  // word address
  typedef logic [DATA_W-1:0] data_t;  // one full bus word

endpackage

/* src/blit_pkg.sv */
package blit_pkg;

  // one copy request, everything execute needs to run a frame
  typedef struct packed {
    mem_pkg::addr_t src_base;  // first source word
    mem_pkg::addr_t dst_base;  // first word of target bank
    logic           bank;      // 1 = bank 1 being drawn
  } blit_job_t;

  // copy engine states
  typedef enum logic [1:0] {
    idle  = 2'd0,
    read  = 2'd1,
    write = 2'd2,
    done  = 2'd3
  } copy_state_t;

endpackage

/* src/blit_if.sv */
`timescale 1ns/1ps

// job handoff, valid/ready
interface blit_job_if;
  import blit_pkg::*;

  logic      valid;
  logic      ready;
  blit_job_t job;   // held while valid waits

  modport source (
    output valid,
    output job,
    input  ready
  );

  modport sink (
    input  valid,
    input  job,
    output ready
  );
endinterface

// progress events from the copy engine
interface blit_evt_if;
  logic start;      // pulse, job accepted
  logic word_done;  // pulse per written word
  logic job_done;   // pulse after last write
  logic bank;       // level, bank of the current job

  modport source (
    output start,
    output word_done,
    output job_done,
    output bank
  );

  modport sink (
    input start,
    input word_done,
    input job_done,
    input bank
  );
endinterface

/* src/blit_decode.sv */
`timescale 1ns/1ps
`include "blit_defaults.svh"

module blit_decode #(
  parameter mem_pkg::addr_t SRC_BASE        = `BLIT_SRC_BASE,
  parameter mem_pkg::addr_t SRC_LANE_STRIDE = `BLIT_SRC_LANE_STRIDE,
  parameter mem_pkg::addr_t DST_BASE0       = `BLIT_DST_BASE0,
  parameter mem_pkg::addr_t DST_BASE1       = `BLIT_DST_BASE1
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       new_frame,
  input  logic [3:0] key,
  input  logic       frame_flip,
  input  logic       busy,
  blit_job_if.source job
);
  import mem_pkg::*;
  import blit_pkg::*;

  logic      accept;
  blit_job_t next_job;

  // drop requests while one is pending or a copy runs
  assign accept = new_frame && !job.valid && !busy;

  always_comb
  begin
    next_job.src_base = SRC_BASE + addr_t'(key) * SRC_LANE_STRIDE;
    next_job.dst_base = frame_flip ? DST_BASE1 : DST_BASE0;
    next_job.bank     = frame_flip;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      job.valid <= 1'b0;
    else if (job.valid && job.ready)
      job.valid <= 1'b0;  // taken by execute
    else if (accept)
      job.valid <= 1'b1;
  end

  // payload, only loaded on accept
  always_ff @(posedge clk)
  begin
    if (accept)
      job.job <= next_job;
  end

  // a waiting job keeps its valid and its contents
  a_job_hold: assert property (
    @(posedge clk) disable iff (reset)
    job.valid && !job.ready |=> job.valid && $stable(job.job)
  );

endmodule

/* src/blit_execute.sv */
`timescale 1ns/1ps
`include "blit_defaults.svh"

module blit_execute #(
  parameter int unsigned    ROW_WORDS   = `BLIT_ROW_WORDS,
  parameter int unsigned    ROWS        = `BLIT_ROWS,
  parameter mem_pkg::addr_t DST_ROW_GAP = `BLIT_DST_ROW_GAP
) (
  input  logic           clk,
  input  logic           reset,
  blit_job_if.sink       job,
  blit_evt_if.source     evt,
  output logic           wb_cyc,
  output logic           wb_stb,
  output logic           wb_we,
  output mem_pkg::addr_t wb_adr,
  output mem_pkg::data_t wb_dat_w,
  input  mem_pkg::data_t wb_dat_r,
  input  logic           wb_ack
);
  import mem_pkg::*;
  import blit_pkg::*;

  localparam int COL_W = $clog2(ROW_WORDS + 1);
  localparam int ROW_W = $clog2(ROWS + 1);

  copy_state_t state;
  logic        req;      // registered cyc/stb
  addr_t       src_ptr;
  addr_t       dst_ptr;
  data_t       rd_data;  // word in flight
  logic        bank_q;
  logic [COL_W-1:0] col_cnt;
  logic [ROW_W-1:0] row_cnt;

  logic accept;
  logic rd_ack;
  logic wr_ack;
  logic row_end;
  logic last_word;

  assign accept    = job.valid && job.ready;
  assign rd_ack    = (state == read) && req && wb_ack;
  assign wr_ack    = (state == write) && req && wb_ack;
  assign row_end   = col_cnt == COL_W'(ROW_WORDS - 1);
  assign last_word = row_end && (row_cnt == ROW_W'(ROWS - 1));

  // control, state and counters
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state   <= idle;
      req     <= 1'b0;
      col_cnt <= '0;
      row_cnt <= '0;
    end
    else
    begin
      case (state)
        idle:
          if (job.valid)
          begin
            state   <= read;
            req     <= 1'b1;  // first read right away
            col_cnt <= '0;
            row_cnt <= '0;
          end
        read:
          if (!req)
            req <= 1'b1;
          else if (wb_ack)
          begin
            state <= write;
            req   <= 1'b0;  // one idle cycle on the bus
          end
        write:
          if (!req)
            req <= 1'b1;
          else if (wb_ack)
          begin
            req   <= 1'b0;
            state <= last_word ? done : read;
            if (row_end)
            begin
              col_cnt <= '0;
              row_cnt <= row_cnt + 1'b1;
            end
            else
              col_cnt <= col_cnt + 1'b1;
          end
        done:
          state <= idle;
        default:
          state <= idle;
      endcase
    end
  end

  // pointers and captured data
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      src_ptr <= job.job.src_base;
      dst_ptr <= job.job.dst_base;
      bank_q  <= job.job.bank;
    end
    else
    begin
      if (rd_ack)
      begin
        rd_data <= wb_dat_r;
        src_ptr <= src_ptr + 1'b1;
      end
      if (wr_ack)
        dst_ptr <= row_end ? dst_ptr + DST_ROW_GAP + 1'b1 : dst_ptr + 1'b1;
    end
  end

  always_comb
  begin
    case (state)
      write:   wb_adr = dst_ptr;
      default: wb_adr = src_ptr;
    endcase
  end

  assign wb_cyc   = req;
  assign wb_stb   = req;
  assign wb_we    = (state == write);
  assign wb_dat_w = rd_data;

  assign job.ready     = (state == idle);
  assign evt.start     = accept;
  assign evt.word_done = wr_ack;
  assign evt.job_done  = (state == done);
  assign evt.bank      = bank_q;

  a_stb_cyc: assert property (
    @(posedge clk) disable iff (reset)
    wb_stb |-> wb_cyc
  );

  // request held through wait states
  a_req_hold: assert property (
    @(posedge clk) disable iff (reset)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we)
  );

  // every read is a read until acked, then a gap, then its write
  a_read_then_write: assert property (
    @(posedge clk) disable iff (reset)
    wb_stb && wb_ack && !wb_we |=> !wb_stb ##1 wb_stb && wb_we
  );

  // a job opens with a read
  a_first_read: assert property (
    @(posedge clk) disable iff (reset)
    evt.start |=> wb_stb && !wb_we
  );

endmodule

/* src/blit_result.sv */
`timescale 1ns/1ps

module blit_result (
  input  logic        clk,
  input  logic        reset,
  blit_evt_if.sink    evt,
  output logic        busy,
  output logic        writedone,
  output logic [7:0]  frame_count,
  output logic [15:0] words_copied
);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy      <= 1'b0;
      writedone <= 1'b0;
    end
    else if (evt.start)
    begin
      busy      <= 1'b1;
      writedone <= 1'b0;
    end
    else if (evt.job_done)
    begin
      busy      <= 1'b0;
      writedone <= 1'b1;  // sticky until next start
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      frame_count <= '0;
    else if (evt.job_done)
      frame_count <= frame_count + 1'b1;  // wraps at 256
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      words_copied <= '0;
    else if (evt.start)
      words_copied <= '0;
    else if (evt.word_done)
      words_copied <= words_copied + 1'b1;
  end

  a_done_in_busy: assert property (
    @(posedge clk) disable iff (reset)
    evt.job_done |-> busy
  );

  // target bank must not change under a running copy
  a_bank_steady: assert property (
    @(posedge clk) disable iff (reset)
    busy && !evt.job_done |=> $stable(evt.bank)
  );

endmodule

/* src/frame_blitter.sv */
`timescale 1ns/1ps
`include "blit_defaults.svh"

module frame_blitter #(
  parameter mem_pkg::addr_t SRC_BASE        = `BLIT_SRC_BASE,
  parameter mem_pkg::addr_t SRC_LANE_STRIDE = `BLIT_SRC_LANE_STRIDE,
  parameter mem_pkg::addr_t DST_BASE0       = `BLIT_DST_BASE0,
  parameter mem_pkg::addr_t DST_BASE1       = `BLIT_DST_BASE1,
  parameter int unsigned    ROW_WORDS       = `BLIT_ROW_WORDS,
  parameter int unsigned    ROWS            = `BLIT_ROWS,
  parameter mem_pkg::addr_t DST_ROW_GAP     = `BLIT_DST_ROW_GAP
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           new_frame,
  input  logic [3:0]     key,
  input  logic           frame_flip,
  output logic           wb_cyc,
  output logic           wb_stb,
  output logic           wb_we,
  output mem_pkg::addr_t wb_adr,
  output mem_pkg::data_t wb_dat_w,
  input  mem_pkg::data_t wb_dat_r,
  input  logic           wb_ack,
  output logic           busy,
  output logic           writedone,
  output logic [7:0]     frame_count,
  output logic [15:0]    words_copied
);

  blit_job_if job_ch ();
  blit_evt_if evt_ch ();

  blit_decode #(
    .SRC_BASE        (SRC_BASE),
    .SRC_LANE_STRIDE (SRC_LANE_STRIDE),
    .DST_BASE0       (DST_BASE0),
    .DST_BASE1       (DST_BASE1)
  ) u_decode (
    .clk        (clk),
    .reset      (reset),
    .new_frame  (new_frame),
    .key        (key),
    .frame_flip (frame_flip),
    .busy       (busy),       // blocks frames during a copy
    .job        (job_ch.source)
  );

  blit_execute #(
    .ROW_WORDS   (ROW_WORDS),
    .ROWS        (ROWS),
    .DST_ROW_GAP (DST_ROW_GAP)
  ) u_execute (
    .clk      (clk),
    .reset    (reset),
    .job      (job_ch.sink),
    .evt      (evt_ch.source),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  blit_result u_result (
    .clk          (clk),
    .reset        (reset),
    .evt          (evt_ch.sink),
    .busy         (busy),
    .writedone    (writedone),
    .frame_count  (frame_count),
    .words_copied (words_copied)
  );

endmodule

/* tests/wb_mem_model.sv */
`timescale 1ns/1ps

// wishbone classic slave with address-derived contents and random wait states
module wb_mem_model (
  input  logic           clk,
  input  logic           reset,
  input  logic           cyc,
  input  logic           stb,
  input  logic           we,
  input  mem_pkg::addr_t adr,
  output mem_pkg::data_t dat_r,
  output logic           ack
);
  import mem_pkg::*;

  logic [15:0] lfsr;
  logic        active;     // counting waits for this access
  logic [1:0]  wait_left;

  // taps 16,14,13,11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // inverted low address bits above the full address
  function automatic data_t mem_word(input addr_t a);
    return {~a[9:0], a};
  endfunction

  always @(posedge clk)
  begin : access
    logic [15:0] s1;
    logic [15:0] s2;
    if (reset)
    begin
      lfsr      <= 16'd9023;
      active    <= 1'b0;
      wait_left <= 2'd0;
      ack       <= 1'b0;
      dat_r     <= '0;
    end
    else
    begin
      ack <= 1'b0;
      if (cyc && stb && !ack)
      begin
        if (!active)
        begin
          s1 = lfsr_step(lfsr);  // one step per bit
          s2 = lfsr_step(s1);
          lfsr      <= s2;
          wait_left <= {s1[0], s2[0]};
          active    <= 1'b1;
        end
        else if (wait_left != 2'd0)
          wait_left <= wait_left - 1'b1;
        else
        begin
          ack    <= 1'b1;
          active <= 1'b0;
          if (!we)
            dat_r <= mem_word(adr);  // writes are taken and dropped
        end
      end
    end
  end

endmodule

/* tests/tb_frame_blitter.sv */
`timescale 1ns/1ps
`include "blit_defaults.svh"

module tb_frame_blitter;
  import mem_pkg::*;

  localparam int    ROW_WORDS  = 4;
  localparam int    ROWS       = 3;
  localparam addr_t ROW_GAP    = 22'd2;
  localparam int    WORDS      = ROW_WORDS * ROWS;
  localparam int    WAIT_LIMIT = 400;
  localparam int    FRAMES     = 5;

  logic       clk = 1'b0;
  logic       reset;
  logic       new_frame;
  logic [3:0] key;
  logic       frame_flip;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  addr_t      wb_adr;
  data_t      wb_dat_w;
  data_t      wb_dat_r;
  logic       wb_ack;
  logic       busy;
  logic       writedone;
  logic [7:0] frame_count;
  logic [15:0] words_copied;

  int    errors;
  int    timeouts;
  int    frames_done;
  int    frames_started;
  int    rd_cnt;       // acked reads this frame
  int    wr_cnt;
  logic  seen_frame;
  logic  quiet_check;  // bus and status must stay idle
  addr_t exp_src;
  addr_t exp_dst;

  logic [3:0] frame_keys  [0:FRAMES-1] = '{4'h0, 4'h5, 4'hF, 4'h3, 4'hA};
  logic       frame_flips [0:FRAMES-1] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1};

  frame_blitter #(
    .ROW_WORDS   (ROW_WORDS),
    .ROWS        (ROWS),
    .DST_ROW_GAP (ROW_GAP)
  ) DUT (
    .clk          (clk),
    .reset        (reset),
    .new_frame    (new_frame),
    .key          (key),
    .frame_flip   (frame_flip),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .busy         (busy),
    .writedone    (writedone),
    .frame_count  (frame_count),
    .words_copied (words_copied)
  );

  wb_mem_model u_mem (
    .clk   (clk),
    .reset (reset),
    .cyc   (wb_cyc),
    .stb   (wb_stb),
    .we    (wb_we),
    .adr   (wb_adr),
    .dat_r (wb_dat_r),
    .ack   (wb_ack)
  );

  always #50 clk = ~clk;

  function automatic data_t expected_word(input addr_t a);
    return {~a[9:0], a};
  endfunction

  // bank base plus one per word plus a row gap after each full row
  function automatic addr_t dst_addr(input int n);
    return exp_dst + addr_t'(n) + addr_t'(n / ROW_WORDS) * ROW_GAP;
  endfunction

  task automatic report_error(input string msg);
    errors = errors + 1;
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  always @(posedge clk)
  begin
    if (reset || !busy)
    begin
      rd_cnt <= 0;
      wr_cnt <= 0;
    end
    else if (wb_stb && wb_ack)
    begin
      if (wb_we)
        wr_cnt <= wr_cnt + 1;
      else
        rd_cnt <= rd_cnt + 1;
    end
  end

  a_idle_after_reset: assert property (@(posedge clk) disable iff (reset)
    !seen_frame |-> !wb_cyc && !busy && !writedone)
    else report_error("activity before the first frame");
  a_read_addr: assert property (@(posedge clk) disable iff (reset)
    wb_stb && !wb_we |-> wb_adr == exp_src + addr_t'(rd_cnt))
    else report_error($sformatf("read address %h, word %0d", wb_adr, rd_cnt));
  a_write_addr: assert property (@(posedge clk) disable iff (reset)
    wb_stb && wb_we |-> wb_adr == dst_addr(wr_cnt))
    else report_error($sformatf("write address %h, word %0d", wb_adr, wr_cnt));
  a_write_data: assert property (@(posedge clk) disable iff (reset)
    wb_stb && wb_we |-> wb_dat_w == expected_word(exp_src + addr_t'(wr_cnt)))
    else report_error($sformatf("write data %h, word %0d", wb_dat_w, wr_cnt));
  a_hold: assert property (@(posedge clk) disable iff (reset)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
    else report_error("request changed during wait states");
  a_busy_in_copy: assert property (@(posedge clk) disable iff (reset)
    wb_cyc |-> busy)
    else report_error("bus cycle while busy is low");
  a_start_clears: assert property (@(posedge clk) disable iff (reset)
    $rose(busy) |-> !writedone)
    else report_error("writedone still high at start");
  a_end_sets: assert property (@(posedge clk) disable iff (reset)
    $fell(busy) |-> writedone)
    else report_error("writedone low at end of copy");
  a_word_total: assert property (@(posedge clk) disable iff (reset)
    $rose(writedone) |-> words_copied == 16'(WORDS) && wr_cnt == WORDS && rd_cnt == WORDS)
    else report_error($sformatf("words_copied %0d, writes %0d", words_copied, wr_cnt));
  a_frame_inc: assert property (@(posedge clk) disable iff (reset)
    $rose(writedone) |-> frame_count == 8'(frames_started))
    else report_error($sformatf("frame_count %0d, expected %0d",
                                frame_count, frames_started));
  a_frame_steady: assert property (@(posedge clk) disable iff (reset)
    !$rose(writedone) |-> $stable(frame_count))
    else report_error("frame_count moved without a finished copy");
  a_quiet: assert property (@(posedge clk) disable iff (reset)
    quiet_check |-> !busy && !wb_cyc)
    else report_error("extra copy started");

  task automatic run_frame(input logic [3:0] k, input logic flip, input logic poke);
    int n;
    exp_src    = `BLIT_SRC_BASE + addr_t'(k) * `BLIT_SRC_LANE_STRIDE;
    exp_dst    = flip ? `BLIT_DST_BASE1 : `BLIT_DST_BASE0;
    key        = k;
    frame_flip = flip;
    new_frame  = 1'b1;
    seen_frame = 1'b1;
    frames_started++;
    next_cycle();
    new_frame = 1'b0;
    n = 0;
    while (!busy && n < WAIT_LIMIT)
    begin
      next_cycle();
      n++;
    end
    if (!busy)
    begin
      timeouts++;
      $display("timeout: copy for key %h never started", k);
    end
    else
    begin
      if (poke)
      begin
        repeat (3) next_cycle();
        key       = ~k;  // would show up in read addresses
        new_frame = 1'b1;
        next_cycle();
        new_frame = 1'b0;
      end
      n = 0;
      while (!writedone && n < WAIT_LIMIT)
      begin
        next_cycle();
        n++;
      end
      if (!writedone)
      begin
        timeouts++;
        $display("timeout: copy for key %h never finished", k);
      end
      else
      begin
        frames_done++;
        quiet_check = 1'b1;
        repeat (6) next_cycle();
        quiet_check = 1'b0;
      end
    end
  endtask

  initial
  begin
    errors         = 0;
    timeouts       = 0;
    frames_done    = 0;
    frames_started = 0;
    seen_frame     = 1'b0;
    quiet_check    = 1'b0;
    exp_src        = '0;
    exp_dst        = '0;
    reset          = 1'b1;
    new_frame      = 1'b0;
    key            = 4'h0;
    frame_flip     = 1'b0;
    repeat (3) @(posedge clk);
    #10;
    reset = 1'b0;
    repeat (4) next_cycle();
    for (int i = 0; i < FRAMES && timeouts == 0; i++)
      run_frame(frame_keys[i], frame_flips[i], i == 1 || i == 3);
    a_final_count: assert (frame_count == 8'(frames_done))
      else report_error($sformatf("final frame_count %0d", frame_count));
    $display("errors: %0d, timeouts: %0d, frames copied: %0d of %0d",
             errors, timeouts, frames_done, FRAMES);
    if (errors == 0 && timeouts == 0 && frames_done == FRAMES)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* files.f */
+incdir+include
src/mem_pkg.sv
src/blit_pkg.sv
src/blit_if.sv
src/blit_decode.sv
src/blit_execute.sv
src/blit_result.sv
src/frame_blitter.sv
tests/wb_mem_model.sv
tests/tb_frame_blitter.sv
